// File: compile.f
logic/stash_pkg.sv
logic/fifo_ctrl.sv
logic/db_core.sv
logic/stash_fifo.sv
logic/stash_regs.sv
logic/stash_top.sv
bench/stash_tb.sv

// File: Makefile
TOP := stash_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: bench/stash_tb.sv
`timescale 1ns/1ps

module stash_tb;

    import stash_pkg::*;

    // ----------------------------------------
    // Run length
    // ----------------------------------------
    localparam int NUM_BATCHES    = 20;
    localparam int BATCH_LEN      = 20;
    localparam int RD_BURST       = 8;
    localparam int NUM_OPS        = NUM_BATCHES * (BATCH_LEN + RD_BURST + 1) + 64;
    localparam int TIMEOUT_CYCLES = 20 * NUM_OPS + 200;

    // Lookups also try a fifth key that is never written
    localparam int KEY_BASE = 8'h3A;

    typedef struct packed {
        key_t   key;
        value_t value;
        logic   valid;
    } entry_t;

    logic       clk;
    logic       __srst;
    logic       init_done;
    logic       wr_req;
    logic       wr_next;
    key_t       wr_key;
    value_t     wr_value;
    logic       wr_valid;
    logic       wr_rdy;
    logic       wr_ack;
    logic       wr_error;
    logic       rd_req;
    logic       rd_next;
    key_t       rd_key;
    logic       rd_rdy;
    logic       rd_ack;
    logic       rd_valid;
    value_t     rd_value;
    key_t       rd_next_key;
    logic       rd_error;
    apb_addr_t  paddr;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_data_t  pwdata;
    apb_data_t  prdata;
    logic       pready;
    logic       pslverr;

    // Reference model with the oldest entry at index 0
    entry_t     model_q [$];
    int         model_pushes;
    int         model_pops;
    int         seed      = 64469;
    int         cycle_cnt = 0;

    stash_top stash_top_i (
        .clk         ( clk ),
        .__srst      ( __srst ),
        .init_done   ( init_done ),
        .wr_req      ( wr_req ),
        .wr_next     ( wr_next ),
        .wr_key      ( wr_key ),
        .wr_value    ( wr_value ),
        .wr_valid    ( wr_valid ),
        .wr_rdy      ( wr_rdy ),
        .wr_ack      ( wr_ack ),
        .wr_error    ( wr_error ),
        .rd_req      ( rd_req ),
        .rd_next     ( rd_next ),
        .rd_key      ( rd_key ),
        .rd_rdy      ( rd_rdy ),
        .rd_ack      ( rd_ack ),
        .rd_valid    ( rd_valid ),
        .rd_value    ( rd_value ),
        .rd_next_key ( rd_next_key ),
        .rd_error    ( rd_error ),
        .paddr       ( paddr ),
        .psel        ( psel ),
        .penable     ( penable ),
        .pwrite      ( pwrite ),
        .pwdata      ( pwdata ),
        .prdata      ( prdata ),
        .pready      ( pready ),
        .pslverr     ( pslverr )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // Failure reporting and checks
    // ----------------------------------------
    task automatic stop_run(input string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1, "stash_tb stopped");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_run($sformatf("timeout: the test did not end within %0d cycles", cycle_cnt));
        end
    end

    task automatic check_flag(input logic actual, input logic expected, input string msg);
        if (actual !== expected) begin
            stop_run($sformatf("mismatch at %0t: %s, got %0b expected %0b",
                               $time, msg, actual, expected));
        end
    endtask

    task automatic check_wr(input logic exp_error, input string msg);
        if (wr_ack !== 1'b1) begin
            stop_run($sformatf("mismatch at %0t: %s, wr_ack missing", $time, msg));
        end else if (wr_error !== exp_error) begin
            stop_run($sformatf("mismatch at %0t: %s, wr_error got %0b expected %0b",
                               $time, msg, wr_error, exp_error));
        end
    endtask

    task automatic check_rd(input logic exp_error, input logic check_data, input logic exp_valid,
                            input value_t exp_value, input key_t exp_key, input string msg);
        if (rd_ack !== 1'b1) begin
            stop_run($sformatf("mismatch at %0t: %s, rd_ack missing", $time, msg));
        end else if (rd_error !== exp_error) begin
            stop_run($sformatf("mismatch at %0t: %s, rd_error got %0b expected %0b",
                               $time, msg, rd_error, exp_error));
        end else if (check_data && (rd_valid !== exp_valid || rd_value !== exp_value ||
                                    rd_next_key !== exp_key)) begin
            stop_run($sformatf("mismatch at %0t: %s, got valid %0b value %04h key %02h, %s",
                               $time, msg, rd_valid, rd_value, rd_next_key,
                               $sformatf("expected valid %0b value %04h key %02h",
                                         exp_valid, exp_value, exp_key)));
        end
    endtask

    task automatic check_reg(input apb_data_t actual, input apb_data_t expected,
                             input string msg);
        if (actual !== expected) begin
            stop_run($sformatf("mismatch at %0t: %s, got %08h expected %08h",
                               $time, msg, actual, expected));
        end
    endtask

    function automatic int pick(input int n);
        return int'({$random(seed)} % n);
    endfunction

    // ----------------------------------------
    // APB accesses
    // ----------------------------------------
    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #2;
        penable = 1'b1;
        #1;
        check_flag(pready, 1'b1, "pready in read access phase");
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #2;
        penable = 1'b1;
        #1;
        check_flag(pready, 1'b1, "pready in write access phase");
        check_flag(pslverr, 1'b0, "pslverr on mapped write");
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic check_status(input string msg);
        apb_data_t data;
        apb_data_t expected;
        logic      err;
        expected      = '0;
        expected[7:0] = 8'(model_q.size());
        expected[8]   = (model_q.size() == 0);
        expected[9]   = (model_q.size() == STASH_SIZE);
        apb_read(REG_STATUS, data, err);
        check_flag(err, 1'b0, "pslverr on STATUS");
        check_reg(data, expected, msg);
    endtask

    task automatic check_counters();
        apb_data_t data;
        logic      err;
        apb_read(REG_PUSH_CNT, data, err);
        check_flag(err, 1'b0, "pslverr on PUSH_CNT");
        check_reg(data, apb_data_t'(model_pushes), "PUSH_CNT register");
        apb_read(REG_POP_CNT, data, err);
        check_flag(err, 1'b0, "pslverr on POP_CNT");
        check_reg(data, apb_data_t'(model_pops), "POP_CNT register");
    endtask

    // ----------------------------------------
    // Application port traffic
    // ----------------------------------------
    task automatic write_entry(input logic next, input key_t key, input value_t value,
                               input logic valid);
        logic   exp_error;
        entry_t entry;
        string  msg;
        wr_req   = 1'b1;
        wr_next  = next;
        wr_key   = key;
        wr_value = value;
        wr_valid = valid;
        while (!wr_rdy) begin
            @(posedge clk);
            #2;
        end
        if (next) begin
            exp_error = (model_q.size() == 0);
            msg       = $sformatf("pop at fill %0d", model_q.size());
        end else begin
            exp_error = (model_q.size() == STASH_SIZE);
            msg       = $sformatf("push of key %02h at fill %0d", key, model_q.size());
        end
        @(posedge clk);
        #2;
        wr_req = 1'b0;
        check_wr(exp_error, msg);
        if (!exp_error) begin
            if (next) begin
                model_q.delete(0);
                model_pops++;
            end else begin
                entry.key   = key;
                entry.value = value;
                entry.valid = valid;
                model_q.push_back(entry);
                model_pushes++;
            end
        end
    endtask

    task automatic expect_read(input logic next, input key_t key);
        logic   found;
        entry_t entry;
        int     i;
        found = 1'b0;
        entry = '0;
        if (next) begin
            if (model_q.size() == 0) begin
                check_rd(1'b1, 1'b0, 1'b0, '0, '0, "head read on empty stash");
            end else begin
                entry = model_q[0];
                check_rd(1'b0, 1'b1, entry.valid, entry.value, entry.key, "head read");
            end
        end else begin
            // Later queue entries are newer so the last match wins
            for (i = 0; i < model_q.size(); i++) begin
                if (model_q[i].key == key) begin
                    found = 1'b1;
                    entry = model_q[i];
                end
            end
            if (found) begin
                check_rd(1'b0, 1'b1, entry.valid, entry.value, '0,
                         $sformatf("lookup hit on key %02h", key));
            end else begin
                check_rd(1'b0, 1'b1, 1'b0, '0, '0, $sformatf("lookup miss on key %02h", key));
            end
        end
    endtask

    // Back-to-back reads answered two cycles after they are driven
    task automatic read_burst();
        logic burst_next [RD_BURST];
        key_t burst_key  [RD_BURST];
        int   p;
        for (p = 0; p < RD_BURST + 2; p++) begin
            if (p >= 2) begin
                expect_read(burst_next[p-2], burst_key[p-2]);
            end else begin
                check_flag(rd_ack, 1'b0, "rd_ack before the first answer is due");
            end
            if (p < RD_BURST) begin
                check_flag(rd_rdy, 1'b1, "rd_rdy during read burst");
                burst_next[p] = (pick(4) == 0);
                burst_key[p]  = key_t'(KEY_BASE + pick(5));
                rd_req  = 1'b1;
                rd_next = burst_next[p];
                rd_key  = burst_key[p];
            end else begin
                rd_req = 1'b0;
            end
            @(posedge clk);
            #2;
        end
    endtask

    task automatic wait_ready(output int low_cycles);
        low_cycles = 0;
        while (!init_done) begin
            @(posedge clk);
            #2;
            low_cycles++;
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        apb_data_t data;
        logic      err;
        int        low_cycles;
        int        batch;
        int        n;
        __srst       = 1'b1;
        wr_req       = 1'b0;
        wr_next      = 1'b0;
        wr_key       = '0;
        wr_value     = '0;
        wr_valid     = 1'b0;
        rd_req       = 1'b0;
        rd_next      = 1'b0;
        rd_key       = '0;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        model_pushes = 0;
        model_pops   = 0;
        repeat (3) @(posedge clk);
        #2;
        __srst = 1'b0;
        wait_ready(low_cycles);

        // Identity and empty status after reset
        apb_read(REG_INFO, data, err);
        check_flag(err, 1'b0, "pslverr on INFO");
        check_reg(data, 32'h0008_0102, "INFO register");
        check_status("STATUS after reset");
        read_burst();

        // Random pushes and pops with reads after each batch
        for (batch = 0; batch < NUM_BATCHES; batch++) begin
            for (n = 0; n < BATCH_LEN; n++) begin
                write_entry(pick(2) == 1, key_t'(KEY_BASE + pick(4)),
                            value_t'($random(seed)), pick(4) != 0);
            end
            check_status($sformatf("STATUS after batch %0d", batch));
            read_burst();
        end

        check_counters();
        apb_read(8'h14, data, err);
        check_flag(err, 1'b1, "pslverr on unmapped offset");

        // Software init empties the stash and clears the counters
        apb_write(REG_CONTROL, 32'h1);
        while (init_done) begin
            @(posedge clk);
            #2;
        end
        check_flag(wr_rdy, 1'b0, "wr_rdy during init");
        check_flag(rd_rdy, 1'b0, "rd_rdy during init");
        wait_ready(low_cycles);
        check_flag(low_cycles == 1, 1'b1, "init lasting one cycle");
        model_q.delete();
        model_pushes = 0;
        model_pops   = 0;
        check_status("STATUS after init");
        check_counters();
        read_burst();

        // Stash refills normally after init
        for (n = 0; n < 10; n++) begin
            write_entry(1'b0, key_t'(KEY_BASE + pick(4)), value_t'($random(seed)), 1'b1);
        end
        check_status("STATUS after refill");
        read_burst();
        check_counters();

        $display("NO ERRORS");
        $finish;
    end

endmodule : stash_tb

// File: logic/stash_top.sv
`timescale 1ns/1ps

module stash_top (
    input  logic                    clk,
    input  logic                    __srst,
    output logic                    init_done,

    // Application write port
    input  logic                    wr_req,
    input  logic                    wr_next,
    input  stash_pkg::key_t         wr_key,
    input  stash_pkg::value_t       wr_value,
    input  logic                    wr_valid,
    output logic                    wr_rdy,
    output logic                    wr_ack,
    output logic                    wr_error,

    // Application read port
    input  logic                    rd_req,
    input  logic                    rd_next,
    input  stash_pkg::key_t         rd_key,
    output logic                    rd_rdy,
    output logic                    rd_ack,
    output logic                    rd_valid,
    output stash_pkg::value_t       rd_value,
    output stash_pkg::key_t         rd_next_key,
    output logic                    rd_error,

    // APB register port
    input  stash_pkg::apb_addr_t    paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  stash_pkg::apb_data_t    pwdata,
    output stash_pkg::apb_data_t    prdata,
    output logic                    pready,
    output logic                    pslverr
);

    import stash_pkg::*;

    // ----------------------------------------
    // Internal wires
    // ----------------------------------------
    logic   local_srst;
    logic   init_req;
    logic   wr_accept;
    logic   push_safe;
    logic   pop_safe;
    fill_t  fill;
    logic   empty;
    logic   full;

    db_core db_core_i (
        .clk        ( clk ),
        .__srst     ( __srst ),
        .init_req   ( init_req ),
        .wr_req     ( wr_req ),
        .wr_next    ( wr_next ),
        .full       ( full ),
        .empty      ( empty ),
        .local_srst ( local_srst ),
        .init_done  ( init_done ),
        .wr_rdy     ( wr_rdy ),
        .rd_rdy     ( rd_rdy ),
        .wr_accept  ( wr_accept ),
        .wr_ack     ( wr_ack ),
        .wr_error   ( wr_error )
    );

    fifo_ctrl fifo_ctrl_i (
        .clk        ( clk ),
        .local_srst ( local_srst ),
        .wr_accept  ( wr_accept ),
        .wr_next    ( wr_next ),
        .push_safe  ( push_safe ),
        .pop_safe   ( pop_safe ),
        .fill       ( fill ),
        .empty      ( empty ),
        .full       ( full )
    );

    stash_fifo stash_fifo_i (
        .clk         ( clk ),
        .local_srst  ( local_srst ),
        .push_safe   ( push_safe ),
        .pop_safe    ( pop_safe ),
        .fill        ( fill ),
        .empty       ( empty ),
        .wr_key      ( wr_key ),
        .wr_value    ( wr_value ),
        .wr_valid    ( wr_valid ),
        .rd_req      ( rd_req ),
        .rd_rdy      ( rd_rdy ),
        .rd_next     ( rd_next ),
        .rd_key      ( rd_key ),
        .rd_ack      ( rd_ack ),
        .rd_valid    ( rd_valid ),
        .rd_value    ( rd_value ),
        .rd_next_key ( rd_next_key ),
        .rd_error    ( rd_error )
    );

    stash_regs stash_regs_i (
        .clk        ( clk ),
        .__srst     ( __srst ),
        .paddr      ( paddr ),
        .psel       ( psel ),
        .penable    ( penable ),
        .pwrite     ( pwrite ),
        .pwdata     ( pwdata ),
        .prdata     ( prdata ),
        .pready     ( pready ),
        .pslverr    ( pslverr ),
        .fill       ( fill ),
        .empty      ( empty ),
        .full       ( full ),
        .push_safe  ( push_safe ),
        .pop_safe   ( pop_safe ),
        .init_req   ( init_req )
    );

endmodule : stash_top

// File: logic/stash_regs.sv
`timescale 1ns/1ps

module stash_regs (
    input  logic                    clk,
    input  logic                    __srst,

    // APB slave
    input  stash_pkg::apb_addr_t    paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  stash_pkg::apb_data_t    pwdata,
    output stash_pkg::apb_data_t    prdata,
    output logic                    pready,
    output logic                    pslverr,

    // Status from the stash
    input  stash_pkg::fill_t        fill,
    input  logic                    empty,
    input  logic                    full,
    input  logic                    push_safe,
    input  logic                    pop_safe,

    output logic                    init_req
);

    import stash_pkg::*;

    // ----------------------------------------
    // Signals
    // ----------------------------------------
    logic       access;
    logic       addr_hit;
    evt_cnt_t   push_cnt;
    evt_cnt_t   pop_cnt;

    // No wait states
    assign access = psel && penable;
    assign pready = access;

    // ----------------------------------------
    // Read decode
    // ----------------------------------------
    always_comb begin
        addr_hit = 1'b1;
        prdata   = '0;
        case (paddr)
            REG_INFO:     prdata = {8'd0, 8'(STASH_SIZE), DB_STASH_TYPE_FIFO, DB_TYPE_STASH};
            REG_STATUS:   prdata = {22'd0, full, empty, 8'(fill)};
            REG_CONTROL:  prdata = '0;
            REG_PUSH_CNT: prdata = {16'd0, push_cnt};
            REG_POP_CNT:  prdata = {16'd0, pop_cnt};
            default:      addr_hit = 1'b0;
        endcase
    end

    assign pslverr = access && !addr_hit;

    // ----------------------------------------
    // Control and event counters
    // ----------------------------------------
    // Single access phase gives a one-cycle pulse
    always_ff @(posedge clk) begin
        if (__srst) begin
            init_req <= 1'b0;
        end else begin
            init_req <= access && pwrite && (paddr == REG_CONTROL) && pwdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (__srst || init_req) begin
            push_cnt <= '0;
            pop_cnt  <= '0;
        end else begin
            if (push_safe) push_cnt <= push_cnt + 1'b1;
            if (pop_safe)  pop_cnt  <= pop_cnt + 1'b1;
        end
    end

    // Access phase only follows a selected setup phase
    penable_in_sel : assert property (
        @(posedge clk) disable iff (__srst)
        penable |-> psel
    ) else $error("stash_regs: penable high without psel");

endmodule : stash_regs

// File: logic/stash_fifo.sv
`timescale 1ns/1ps

module stash_fifo (
    input  logic                clk,
    input  logic                local_srst,

    // Protected strobes and occupancy from the FIFO controller
    input  logic                push_safe,
    input  logic                pop_safe,
    input  stash_pkg::fill_t    fill,
    input  logic                empty,

    // Write payload
    input  stash_pkg::key_t     wr_key,
    input  stash_pkg::value_t   wr_value,
    input  logic                wr_valid,

    // Read request
    input  logic                rd_req,
    input  logic                rd_rdy,
    input  logic                rd_next,
    input  stash_pkg::key_t     rd_key,

    // Read response
    output logic                rd_ack,
    output logic                rd_valid,
    output stash_pkg::value_t   rd_value,
    output stash_pkg::key_t     rd_next_key,
    output logic                rd_error
);

    import stash_pkg::*;

    // ----------------------------------------
    // Signals
    // ----------------------------------------
    key_t                   stash_key   [STASH_SIZE];
    value_t                 stash_value [STASH_SIZE];
    logic [STASH_SIZE-1:0]  stash_valid;
    logic [STASH_SIZE-1:0]  slot_used;

    idx_t                   head_idx;
    logic                   rd_accept;

    // First pipeline stage
    logic                   rd_p1;
    logic                   next_p1;
    logic [STASH_SIZE-1:0]  slot_match;
    logic [STASH_SIZE-1:0]  slot_valid_p1;
    value_t                 slot_value_p1 [STASH_SIZE];
    logic                   head_valid;
    value_t                 head_value;
    key_t                   head_key;
    logic                   head_empty;

    // Match select
    logic                   hit;
    idx_t                   hit_idx;

    // Oldest entry sits just below the fill level
    assign head_idx  = idx_t'(fill - fill_t'(1));
    assign rd_accept = rd_req && rd_rdy;

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    // New entries always enter at slot 0
    always_ff @(posedge clk) begin
        if (push_safe) begin
            for (int i = 1; i < STASH_SIZE; i++) begin
                stash_key[i]   <= stash_key[i-1];
                stash_value[i] <= stash_value[i-1];
                stash_valid[i] <= stash_valid[i-1];
            end
            stash_key[0]   <= wr_key;
            stash_value[0] <= wr_value;
            stash_valid[0] <= wr_valid;
        end
    end

    // Popped head drops out of the lookup
    always_ff @(posedge clk) begin
        if (local_srst) begin
            slot_used <= '0;
        end else if (push_safe) begin
            slot_used <= {slot_used[STASH_SIZE-2:0], 1'b1};
        end else if (pop_safe) begin
            slot_used[head_idx] <= 1'b0;
        end
    end

    // ----------------------------------------
    // Read stage 1
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (local_srst) begin
            rd_p1 <= 1'b0;
        end else begin
            rd_p1 <= rd_accept;
        end
    end

    always_ff @(posedge clk) begin
        next_p1 <= rd_next;
        for (int i = 0; i < STASH_SIZE; i++) begin
            slot_match[i]    <= slot_used[i] && (stash_key[i] == rd_key);
            slot_valid_p1[i] <= stash_valid[i];
            slot_value_p1[i] <= stash_value[i];
        end
        head_valid <= stash_valid[head_idx];
        head_value <= stash_value[head_idx];
        head_key   <= stash_key[head_idx];
        head_empty <= empty;
    end

    // Lowest matching slot is the newest entry
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = STASH_SIZE - 1; i >= 0; i--) begin
            if (slot_match[i]) begin
                hit     = 1'b1;
                hit_idx = idx_t'(i);
            end
        end
    end

    // ----------------------------------------
    // Read stage 2
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (local_srst) begin
            rd_ack <= 1'b0;
        end else begin
            rd_ack <= rd_p1;
        end
    end

    always_ff @(posedge clk) begin
        if (next_p1) begin
            rd_valid    <= head_valid;
            rd_value    <= head_value;
            rd_next_key <= head_key;
            rd_error    <= head_empty;
        end else begin
            rd_valid    <= hit && slot_valid_p1[hit_idx];
            rd_value    <= hit ? slot_value_p1[hit_idx] : '0;
            rd_next_key <= '0;
            rd_error    <= 1'b0;
        end
    end

    // Slot occupancy tracks the controller's count
    used_matches_fill : assert property (
        @(posedge clk) disable iff (local_srst)
        $countones(slot_used) == int'(fill)
    ) else $error("stash_fifo: occupied slots disagree with fill");

endmodule : stash_fifo

// File: logic/db_core.sv
`timescale 1ns/1ps

module db_core (
    input  logic    clk,
    input  logic    __srst,

    // Software init request
    input  logic    init_req,

    // Application write request
    input  logic    wr_req,
    input  logic    wr_next,

    // Occupancy flags for the error response
    input  logic    full,
    input  logic    empty,

    output logic    local_srst,
    output logic    init_done,
    output logic    wr_rdy,
    output logic    rd_rdy,
    output logic    wr_accept,
    output logic    wr_ack,
    output logic    wr_error
);

    import stash_pkg::*;

    // ----------------------------------------
    // Init state machine
    // ----------------------------------------
    core_state_t state;

    always_ff @(posedge clk) begin
        if (__srst) begin
            state <= CORE_RESET;
        end else begin
            case (state)
                CORE_RESET: state <= CORE_INIT;
                CORE_INIT:  state <= CORE_READY;
                CORE_READY: begin
                    if (init_req) begin
                        state <= CORE_INIT;
                    end
                end
                default:    state <= CORE_RESET;
            endcase
        end
    end

    // Storage is held in reset until the core is ready
    assign local_srst = (state != CORE_READY);

    assign init_done = (state == CORE_READY);
    assign wr_rdy    = (state == CORE_READY);
    assign rd_rdy    = (state == CORE_READY);

    assign wr_accept = wr_req && wr_rdy;

    // ----------------------------------------
    // Write response
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            wr_ack <= 1'b0;
        end else begin
            wr_ack <= wr_accept;
        end
    end

    // Pop fails on empty and push fails on full
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            wr_error <= wr_next ? empty : full;
        end
    end

    // Every ack belongs to a write accepted one cycle earlier
    ack_after_accept : assert property (
        @(posedge clk) disable iff (__srst)
        wr_ack |-> $past(wr_accept)
    ) else $error("db_core: wr_ack without a preceding acceptance");

endmodule : db_core

// File: logic/fifo_ctrl.sv
`timescale 1ns/1ps

module fifo_ctrl (
    input  logic                clk,
    input  logic                local_srst,

    // Accepted write transaction from the core
    input  logic                wr_accept,
    input  logic                wr_next,

    // Protected strobes towards storage and counters
    output logic                push_safe,
    output logic                pop_safe,

    // Occupancy
    output stash_pkg::fill_t    fill,
    output logic                empty,
    output logic                full
);

    import stash_pkg::*;

    // ----------------------------------------
    // Signals
    // ----------------------------------------
    fill_t fill_q;

    // ----------------------------------------
    // Overflow and underflow protection
    // ----------------------------------------
    // Push on a full stash and pop on an empty one are dropped
    assign push_safe = wr_accept && !wr_next && !full;
    assign pop_safe  = wr_accept &&  wr_next && !empty;

    // ----------------------------------------
    // Occupancy count
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (local_srst) begin
            fill_q <= '0;
        end else if (push_safe) begin
            fill_q <= fill_q + fill_t'(1);
        end else if (pop_safe) begin
            fill_q <= fill_q - fill_t'(1);
        end
    end

    assign fill  = fill_q;
    assign empty = (fill_q == '0);
    assign full  = (fill_q == fill_t'(STASH_SIZE));

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // Count stays within the storage depth
    fill_in_range : assert property (
        @(posedge clk) disable iff (local_srst)
        fill_q <= fill_t'(STASH_SIZE)
    ) else $error("fifo_ctrl: occupancy above STASH_SIZE");

    // Push and pop share one write port and never fire together
    strobes_excl : assert property (
        @(posedge clk) disable iff (local_srst)
        !(push_safe && pop_safe)
    ) else $error("fifo_ctrl: push and pop in the same cycle");

endmodule : fifo_ctrl

// File: logic/stash_pkg.sv
package stash_pkg;

    // ----------------------------------------
    // Entry geometry
    // ----------------------------------------
    localparam int KEY_WID    = 8;
    localparam int VALUE_WID  = 16;
    localparam int STASH_SIZE = 8;

    localparam int IDX_WID  = $clog2(STASH_SIZE);
    localparam int FILL_WID = $clog2(STASH_SIZE + 1);

    typedef logic [KEY_WID-1:0]   key_t;
    typedef logic [VALUE_WID-1:0] value_t;
    typedef logic [IDX_WID-1:0]   idx_t;
    typedef logic [FILL_WID-1:0]  fill_t;

    // ----------------------------------------
    // APB register side
    // ----------------------------------------
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [15:0] evt_cnt_t;

    // Info codes reported in INFO
    localparam logic [7:0] DB_TYPE_STASH      = 8'd2;
    localparam logic [7:0] DB_STASH_TYPE_FIFO = 8'd1;

    // Register map
    localparam apb_addr_t REG_INFO     = 8'h00;
    localparam apb_addr_t REG_STATUS   = 8'h04;
    localparam apb_addr_t REG_CONTROL  = 8'h08;
    localparam apb_addr_t REG_PUSH_CNT = 8'h0C;
    localparam apb_addr_t REG_POP_CNT  = 8'h10;

    // ----------------------------------------
    // Init sequencing
    // ----------------------------------------
    typedef enum logic [1:0] {
        CORE_RESET,
        CORE_INIT,
        CORE_READY
    } core_state_t;

endpackage : stash_pkg
